// ==== compile.f ====
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_pc_unit.sv
rtl/rv_control.sv
rtl/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

// ==== rtl/rv_alu.sv ====
/* integer ALU for the core, plus the RV32I branch compare on the same operands */
module rv_alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         alu_op,
    input  logic [2:0]      funct3,
    output logic [xlen-1:0] result,
    output logic            branch_taken
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // a and b are rs1 and rs2 for branches
    always_comb begin
        case (funct3)
            beq:     branch_taken = (a == b);
            bne:     branch_taken = (a != b);
            blt:     branch_taken = ($signed(a) < $signed(b));
            bge:     branch_taken = ($signed(a) >= $signed(b));
            bltu:    branch_taken = (a < b);
            bgeu:    branch_taken = (a >= b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/rv_control.sv ====
/* instruction-cycle FSM; runs fetch, execute and the LW/SW transfers on the
   AXI4-Lite channels and strobes the instruction, register and PC updates */
module rv_control (
    input  logic clk,
    input  logic reset,
    input  logic is_load,
    input  logic is_store,
    input  logic is_halt,
    input  logic axi_arready,
    input  logic axi_rvalid,
    input  logic axi_awready,
    input  logic axi_wready,
    input  logic axi_bvalid,
    output logic inst_load,
    output logic reg_we_sel_load,
    output logic exec_done,
    output logic halted,
    output logic axi_arvalid,
    output logic axi_rready,
    output logic axi_awvalid,
    output logic axi_wvalid,
    output logic axi_bready
);
    typedef enum logic [2:0] {
        s_fetch,
        s_fetch_wait,
        s_execute,
        s_load_addr,
        s_load_wait,
        s_store,
        s_store_resp,
        s_halt
    } state_t;

    state_t state;
    state_t state_next;
    logic   aw_ok;
    logic   w_ok;

    // channel done now or on an earlier cycle
    assign aw_ok = !axi_awvalid || axi_awready;
    assign w_ok  = !axi_wvalid || axi_wready;

    always_comb begin
        state_next = state;
        case (state)
            s_fetch:      if (axi_arvalid && axi_arready) state_next = s_fetch_wait;
            s_fetch_wait: if (axi_rvalid && axi_rready) state_next = s_execute;
            s_execute: begin
                if (is_halt)       state_next = s_halt;
                else if (is_load)  state_next = s_load_addr;
                else if (is_store) state_next = s_store;
                else               state_next = s_fetch;
            end
            s_load_addr:  if (axi_arvalid && axi_arready) state_next = s_load_wait;
            s_load_wait:  if (axi_rvalid && axi_rready) state_next = s_fetch;
            s_store:      if (aw_ok && w_ok) state_next = s_store_resp;
            s_store_resp: if (axi_bvalid && axi_bready) state_next = s_fetch;
            default:      state_next = s_halt;  // stays until reset
        endcase
    end

    // channel outputs are registered from the next state
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= s_fetch;
            axi_arvalid <= 1'b0;
            axi_rready  <= 1'b0;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            axi_bready  <= 1'b0;
            halted      <= 1'b0;
        end else begin
            state       <= state_next;
            axi_arvalid <= (state_next == s_fetch) || (state_next == s_load_addr);
            axi_rready  <= (state_next == s_fetch_wait) || (state_next == s_load_wait);
            axi_awvalid <= (state_next == s_store) && (state != s_store || !aw_ok);
            axi_wvalid  <= (state_next == s_store) && (state != s_store || !w_ok);
            axi_bready  <= (state_next == s_store_resp);
            halted      <= (state_next == s_halt);
        end
    end

    assign inst_load       = (state == s_fetch_wait) && axi_rvalid && axi_rready;
    assign exec_done       = (state == s_execute) && !is_halt;
    assign reg_we_sel_load = (state == s_load_wait) && axi_rvalid && axi_rready;

endmodule

// ==== rtl/rv_core.sv ====
/* multicycle RV32I core; one AXI4-Lite master port carries both the
   instruction fetch and the LW/SW data accesses */
module rv_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] axi_araddr,
    output logic            axi_arvalid,
    input  logic            axi_arready,
    input  logic [xlen-1:0] axi_rdata,
    input  logic            axi_rvalid,
    output logic            axi_rready,
    output logic [xlen-1:0] axi_awaddr,
    output logic            axi_awvalid,
    input  logic            axi_awready,
    output logic [xlen-1:0] axi_wdata,
    output logic            axi_wvalid,
    input  logic            axi_wready,
    input  logic            axi_bvalid,
    output logic            axi_bready,
    output logic            halted
);
    rv_inst_u              inst;  // instruction register
    logic [reg_addr_w-1:0] rd, rs1, rs2;
    logic [xlen-1:0]       imm, rdata1, rdata2, wdata;
    logic [xlen-1:0]       alu_a, alu_b, alu_result;
    logic [xlen-1:0]       pc, pc_plus4, jump_target;
    alu_op_t               alu_op;
    logic [2:0]            funct3;
    logic                  use_imm, use_pc, is_load, is_store, is_branch;
    logic                  is_jump, is_jalr, writes_rd, is_halt;
    logic                  inst_load, reg_we_sel_load, exec_done;
    logic                  branch_taken, take_jump, pc_en, reg_we;
    logic                  data_read;  // read channel carries load data, not a fetch

    always_ff @(posedge clk) begin
        if (inst_load) begin
            inst <= axi_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_read <= 1'b0;
        end else if (exec_done && is_load) begin
            data_read <= 1'b1;
        end else if (reg_we_sel_load) begin
            data_read <= 1'b0;
        end
    end

    assign alu_a       = use_pc ? pc : rdata1;
    assign alu_b       = use_imm ? imm : rdata2;
    assign take_jump   = is_jump || (is_branch && branch_taken);
    assign jump_target = is_jalr ? alu_result : pc + imm;
    // loads write back and step the PC on the read-data handshake
    assign pc_en  = (exec_done && !is_load) || reg_we_sel_load;
    assign reg_we = (exec_done && writes_rd && !is_load) || reg_we_sel_load;
    assign wdata  = reg_we_sel_load ? axi_rdata : (is_jump ? pc_plus4 : alu_result);

    assign axi_araddr = data_read ? alu_result : pc;
    assign axi_awaddr = alu_result;
    assign axi_wdata  = rdata2;

    rv_control control_i (.*);

    rv_decode decode_i (.*);

    rv_alu alu_i (
        .a            (alu_a),
        .b            (alu_b),
        .alu_op       (alu_op),
        .funct3       (funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_regfile regfile_i (
        .clk    (clk),
        .reset  (reset),
        .we     (reg_we),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_pc_unit #(.reset_pc(reset_pc)) pc_unit_i (.*);

endmodule

// ==== rtl/rv_decode.sv ====
/* combinational instruction decoder; fields, sign-extended immediate,
   ALU operation and the control flags used by the datapath and the FSM */
module rv_decode import rv_pkg::*; (
    input  rv_inst_u              inst,
    output logic [reg_addr_w-1:0] rd,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [xlen-1:0]       imm,
    output alu_op_t               alu_op,
    output logic [2:0]            funct3,
    output logic                  use_imm,
    output logic                  use_pc,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch,
    output logic                  is_jump,
    output logic                  is_jalr,
    output logic                  writes_rd,
    output logic                  is_halt
);
    logic [31:0] w;  // raw bits for the B, U and J scrambles

    // common to register and immediate forms with sub only in the register form
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                         input logic reg_form);
        case (f3)
            3'b000:  return (alt && reg_form) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign w      = inst;
    assign rd     = inst.r_fmt.rd;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign funct3 = inst.r_fmt.funct3;

    always_comb begin
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        writes_rd = 1'b0;
        is_halt   = 1'b0;
        case (inst.r_fmt.opcode)
            op: begin
                writes_rd = 1'b1;
                alu_op    = arith_op(funct3, inst.r_fmt.funct7[5], 1'b1);
            end
            op_imm: begin
                use_imm   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{w[31]}}, inst.is_fmt.upper};
                alu_op    = arith_op(funct3, inst.is_fmt.upper[10], 1'b0);  // srai bit
            end
            load: begin
                use_imm   = 1'b1;
                is_load   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{w[31]}}, inst.is_fmt.upper};
                is_halt   = (funct3 != 3'b010);  // lw only
            end
            store: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                imm      = {{20{w[31]}}, inst.is_fmt.upper[11:5], inst.is_fmt.low};
                is_halt  = (funct3 != 3'b010);  // sw only
            end
            branch: begin
                is_branch = 1'b1;
                imm       = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                is_halt   = !(funct3 inside {beq, bne, blt, bge, bltu, bgeu});
            end
            jal: begin
                is_jump   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            jalr: begin
                use_imm   = 1'b1;
                is_jump   = 1'b1;
                is_jalr   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{w[31]}}, inst.is_fmt.upper};
            end
            lui, auipc: begin
                use_imm   = 1'b1;
                use_pc    = (inst.r_fmt.opcode == auipc);
                writes_rd = 1'b1;
                imm       = {w[31:12], 12'b0};
                alu_op    = (inst.r_fmt.opcode == lui) ? alu_pass_b : alu_add;
            end
            default: is_halt = 1'b1;  // ebreak, other system words, unknown opcodes
        endcase
    end

endmodule

// ==== rtl/rv_pc_unit.sv ====
/* program counter; steps by 4 or takes the jump target when pc_en is high */
module rv_pc_unit import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pc_en,
    input  logic            take_jump,
    input  logic [xlen-1:0] jump_target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus4
);

    assign pc_plus4 = pc + 4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_en) begin
            // bit 0 cleared for jalr, already zero for jal and branches
            pc <= take_jump ? {jump_target[xlen-1:1], 1'b0} : pc_plus4;
        end
    end

endmodule

// ==== rtl/rv_pkg.sv ====
/* widths, opcodes, ALU operations and instruction layouts for the RV32I core
   imported by each RTL module that uses them */
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_t;

    // one fetched word, seen as R format or as I/S format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] upper;  // I immediate, or S imm[11:5] plus rs2
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  low;    // rd, or S imm[4:0]
            logic [6:0]  opcode;
        } is_fmt;
    } rv_inst_u;

    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

// ==== rtl/rv_regfile.sv ====
/* 32 x xlen register file, two combinational reads and one clocked write */
module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== sim/rv_core_props.sv ====
/* AXI4-Lite handshake and halt assertions, attached to every rv_core by bind */
module rv_core_props import rv_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic [xlen-1:0] axi_araddr,
    input logic            axi_arvalid,
    input logic            axi_arready,
    input logic [xlen-1:0] axi_awaddr,
    input logic            axi_awvalid,
    input logic            axi_awready,
    input logic [xlen-1:0] axi_wdata,
    input logic            axi_wvalid,
    input logic            axi_wready,
    input logic            halted
);
    int fail_count = 0;

    // valid and payload held until the slave takes them
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
        else begin
            $error("arvalid dropped or araddr changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
        else begin
            $error("awvalid dropped or awaddr changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata))
        else begin
            $error("wvalid dropped or wdata changed before wready");
            fail_count++;
        end

    // halt is sticky until reset and nothing new starts
    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted && !axi_arvalid && !axi_awvalid && !axi_wvalid)
        else begin
            $error("halted dropped or new request issued while halted");
            fail_count++;
        end

endmodule

bind rv_core rv_core_props props_i (.*);

// ==== sim/rv_core_tb.sv ====
/* testbench for rv_core; AXI4-Lite memory slave with optional random delays,
   one short program per table row, stored result checked at 0x300 */
module rv_core_tb;

    localparam logic [6:0]  opc_op     = 7'b0110011;
    localparam logic [6:0]  opc_op_imm = 7'b0010011;
    localparam logic [6:0]  opc_load   = 7'b0000011;
    localparam logic [6:0]  opc_jalr   = 7'b1100111;
    localparam logic [6:0]  opc_lui    = 7'b0110111;
    localparam logic [6:0]  opc_auipc  = 7'b0010111;
    localparam logic [31:0] ebreak     = 32'h0010_0073;

    typedef struct packed {
        logic [31:0] inst;  // placed at 0x08
        logic [4:0]  src;   // register stored to 0x300
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] want;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] axi_araddr, axi_rdata, axi_awaddr, axi_wdata;
    logic        axi_arvalid, axi_arready, axi_rvalid, axi_rready;
    logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready;
    logic        axi_bvalid, axi_bready, halted;

    logic [31:0] mem [256];
    row_t        rows [$];
    integer      seed = 32'hd879a5ab;
    int          delay_max = 0;
    int          value_errors = 0;
    int          timeouts = 0;

    // slave state
    int          ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic        r_pend, b_pend, aw_have, w_have;
    logic [31:0] r_word, aw_addr, w_word;
    logic        seen_arvalid, seen_rready, seen_awvalid, seen_wvalid, seen_bready;
    logic [31:0] seen_araddr, seen_awaddr, seen_wdata;

    rv_core #(.reset_pc(32'h0)) rv_core_i (.*);

    always #4 clk = ~clk;

    function automatic int pick_delay();
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % (delay_max + 1);
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};  // sw rs2, imm(x0)
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [4:0] src,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] want);
        row_t r;
        r.inst = inst;
        r.src  = src;
        r.a    = a;
        r.b    = b;
        r.want = want;
        rows.push_back(r);
    endtask

    task automatic reg_op_row(input logic [6:0] f7, input logic [2:0] f3,
                              input logic [31:0] a, input logic [31:0] b, input logic [31:0] want);
        add_row({f7, 5'd2, 5'd1, f3, 5'd3, opc_op}, 5'd3, a, b, want);  // op x3, x1, x2
    endtask

    task automatic imm_op_row(input logic [11:0] imm, input logic [2:0] f3,
                              input logic [31:0] a, input logic [31:0] want);
        add_row(i_format(imm, 5'd1, f3, 5'd3, opc_op_imm), 5'd3, a, 32'h0, want);
    endtask

    // taken jumps +12 to the code that stores 0x7b, not taken stores x3 = 0
    task automatic branch_row(input logic [2:0] f3, input logic [31:0] a,
                              input logic [31:0] b, input logic taken);
        add_row(branch_word(13'd12, f3), 5'd3, a, b, taken ? 32'h7b : 32'h0);
    endtask

    task automatic build_table();
        reg_op_row(7'h00, 3'd0, 32'hffff_fff0, 32'h3, 32'hffff_fff3);
        reg_op_row(7'h20, 3'd0, 32'hffff_fff0, 32'h3, 32'hffff_ffed);
        reg_op_row(7'h20, 3'd0, 32'h7, 32'h9, 32'hffff_fffe);
        reg_op_row(7'h00, 3'd1, 32'h1, 32'h21, 32'h2);  // only 5 shift bits count
        reg_op_row(7'h00, 3'd1, 32'hffff_fff0, 32'h3, 32'hffff_ff80);
        reg_op_row(7'h00, 3'd2, 32'hffff_fff0, 32'h3, 32'h1);
        reg_op_row(7'h00, 3'd3, 32'hffff_fff0, 32'h3, 32'h0);
        reg_op_row(7'h00, 3'd2, 32'h3, 32'hffff_fff0, 32'h0);
        reg_op_row(7'h00, 3'd3, 32'h3, 32'hffff_fff0, 32'h1);
        reg_op_row(7'h00, 3'd4, 32'h0f0f_1234, 32'h00ff_ff00, 32'h0ff0_ed34);
        reg_op_row(7'h00, 3'd5, 32'h8000_0010, 32'h4, 32'h0800_0001);
        reg_op_row(7'h20, 3'd5, 32'h8000_0010, 32'h4, 32'hf800_0001);
        reg_op_row(7'h00, 3'd6, 32'h0f0f_1234, 32'h00ff_ff00, 32'h0fff_ff34);
        reg_op_row(7'h00, 3'd7, 32'h0f0f_1234, 32'h00ff_ff00, 32'h000f_1200);
        imm_op_row(12'hffb, 3'd0, 32'hffff_fff0, 32'hffff_ffeb);
        imm_op_row(12'h005, 3'd2, 32'hffff_fff0, 32'h1);
        imm_op_row(12'h005, 3'd3, 32'hffff_fff0, 32'h0);
        imm_op_row(12'hfff, 3'd3, 32'h5, 32'h1);  // immediate sign-extends before compare
        imm_op_row(12'h0ff, 3'd4, 32'hffff_fff0, 32'hffff_ff0f);
        imm_op_row(12'h00f, 3'd6, 32'hffff_fff0, 32'hffff_ffff);
        imm_op_row(12'h7f0, 3'd7, 32'hffff_fff0, 32'h0000_07f0);
        imm_op_row(12'h004, 3'd1, 32'hffff_fff0, 32'hffff_ff00);
        imm_op_row(12'h004, 3'd5, 32'h8000_0010, 32'h0800_0001);
        imm_op_row(12'h404, 3'd5, 32'h8000_0010, 32'hf800_0001);
        add_row({20'h12345, 5'd3, opc_lui}, 5'd3, 32'h0, 32'h0, 32'h1234_5000);
        add_row({20'h80000, 5'd3, opc_lui}, 5'd3, 32'h0, 32'h0, 32'h8000_0000);
        add_row({20'hfffff, 5'd3, opc_auipc}, 5'd3, 32'h0, 32'h0, 32'hffff_f008);
        add_row(i_format(12'h055, 5'd1, 3'd0, 5'd0, opc_op_imm), 5'd0, 32'h1234, 32'h0, 32'h0);
        add_row(jal_word(21'd16, 5'd3), 5'd3, 32'h0, 32'h0, 32'h0000_000c);
        add_row(i_format(12'h000, 5'd1, 3'd0, 5'd3, opc_jalr), 5'd3, 32'h19, 32'h0, 32'hc);
        branch_row(3'b000, 32'h5, 32'h5, 1'b1);
        branch_row(3'b000, 32'h5, 32'h6, 1'b0);
        branch_row(3'b001, 32'h5, 32'h6, 1'b1);
        branch_row(3'b001, 32'h5, 32'h5, 1'b0);
        branch_row(3'b100, 32'hffff_ffff, 32'h1, 1'b1);
        branch_row(3'b100, 32'h1, 32'hffff_ffff, 1'b0);
        branch_row(3'b101, 32'h1, 32'hffff_ffff, 1'b1);
        branch_row(3'b101, 32'hffff_ffff, 32'h1, 1'b0);
        branch_row(3'b101, 32'h3, 32'h3, 1'b1);
        branch_row(3'b110, 32'h1, 32'hffff_ffff, 1'b1);
        branch_row(3'b110, 32'hffff_ffff, 32'h1, 1'b0);
        branch_row(3'b111, 32'hffff_ffff, 32'h1, 1'b1);
        branch_row(3'b111, 32'h1, 32'hffff_ffff, 1'b0);
    endtask

    task automatic load_program(input row_t r);
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 | (i << 2);  // word holds its own byte address
        end
        mem[0]   = i_format(12'h200, 5'd0, 3'b010, 5'd1, opc_load);  // lw x1, 0x200
        mem[1]   = i_format(12'h204, 5'd0, 3'b010, 5'd2, opc_load);  // lw x2, 0x204
        mem[2]   = r.inst;
        mem[3]   = s_format(12'h300, r.src);
        mem[4]   = ebreak;
        mem[5]   = i_format(12'h07b, 5'd0, 3'd0, 5'd3, opc_op_imm);  // branch target
        mem[6]   = s_format(12'h300, 5'd3);                          // jal/jalr target
        mem[7]   = ebreak;
        mem[128] = r.a;
        mem[129] = r.b;
    endtask

    // slave model driving every ready and valid on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            axi_arready  = 1'b0;
            axi_rvalid   = 1'b0;
            axi_awready  = 1'b0;
            axi_wready   = 1'b0;
            axi_bvalid   = 1'b0;
            r_pend       = 1'b0;
            b_pend       = 1'b0;
            aw_have      = 1'b0;
            w_have       = 1'b0;
            ar_cnt       = 0;
            aw_cnt       = 0;
            w_cnt        = 0;
            seen_arvalid = 1'b0;
            seen_rready  = 1'b0;
            seen_awvalid = 1'b0;
            seen_wvalid  = 1'b0;
            seen_bready  = 1'b0;
        end else begin
            // transfers completed on the last rising edge
            if (seen_arvalid && axi_arready) begin
                axi_arready = 1'b0;
                r_pend      = 1'b1;
                r_cnt       = pick_delay();
                r_word      = mem[seen_araddr[9:2]];
            end
            if (seen_rready && axi_rvalid) begin
                axi_rvalid = 1'b0;
                ar_cnt     = pick_delay();
            end
            if (seen_awvalid && axi_awready) begin
                axi_awready = 1'b0;
                aw_have     = 1'b1;
                aw_addr     = seen_awaddr;
            end
            if (seen_wvalid && axi_wready) begin
                axi_wready = 1'b0;
                w_have     = 1'b1;
                w_word     = seen_wdata;
            end
            if (seen_bready && axi_bvalid) begin
                axi_bvalid = 1'b0;
                aw_cnt     = pick_delay();
                w_cnt      = pick_delay();
            end
            if (aw_have && w_have) begin
                mem[aw_addr[9:2]] = w_word;
                aw_have           = 1'b0;
                w_have            = 1'b0;
                b_pend            = 1'b1;
                b_cnt             = pick_delay();
            end
            // readies and responses after their delay
            if (axi_arvalid && !axi_arready) begin
                if (ar_cnt == 0) axi_arready = 1'b1;
                else ar_cnt--;
            end
            if (axi_awvalid && !axi_awready) begin
                if (aw_cnt == 0) axi_awready = 1'b1;
                else aw_cnt--;
            end
            if (axi_wvalid && !axi_wready) begin
                if (w_cnt == 0) axi_wready = 1'b1;
                else w_cnt--;
            end
            if (r_pend) begin
                if (r_cnt == 0) begin
                    axi_rvalid = 1'b1;
                    axi_rdata  = r_word;
                    r_pend     = 1'b0;
                end else begin
                    r_cnt--;
                end
            end
            if (b_pend) begin
                if (b_cnt == 0) begin
                    axi_bvalid = 1'b1;
                    b_pend     = 1'b0;
                end else begin
                    b_cnt--;
                end
            end
            seen_arvalid = axi_arvalid;
            seen_araddr  = axi_araddr;
            seen_rready  = axi_rready;
            seen_awvalid = axi_awvalid;
            seen_awaddr  = axi_awaddr;
            seen_wvalid  = axi_wvalid;
            seen_wdata   = axi_wdata;
            seen_bready  = axi_bready;
        end
    end

    task automatic run_row(input int n, input int pass);
        int cyc;
        @(negedge clk);
        reset <= 1'b1;
        repeat (2) @(negedge clk);
        delay_max = (pass == 0) ? 0 : 3;
        load_program(rows[n]);
        repeat (2) @(negedge clk);
        if ({axi_arvalid, axi_rready, axi_awvalid, axi_wvalid, axi_bready, halted} !== 6'b0) begin
            value_errors++;
            $display("Fail at %0t: {arvalid,rready,awvalid,wvalid,bready,halted} got %b expected %b",
                     $time, {axi_arvalid, axi_rready, axi_awvalid, axi_wvalid, axi_bready, halted},
                     6'b0);
        end
        reset <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        // first fetch request right after reset release
        if (axi_arvalid !== 1'b1 || axi_araddr !== 32'h0) begin
            value_errors++;
            $display("Fail at %0t: {arvalid,araddr} got %b,%h expected 1,%h",
                     $time, axi_arvalid, axi_araddr, 32'h0);
        end
        for (cyc = 0; cyc < 4000 && halted !== 1'b1; cyc++) begin
            @(negedge clk);
        end
        if (halted !== 1'b1) begin
            timeouts++;
            $display("row %0d pass %0d: core did not halt within %0d cycles", n, pass, cyc);
        end else begin
            if (mem[192] !== rows[n].want) begin
                value_errors++;
                $display("Fail at %0t: mem[0x300] got %h expected %h (row %0d, pass %0d)",
                         $time, mem[192], rows[n].want, n, pass);
            end
            for (cyc = 0; cyc < 50; cyc++) begin
                @(negedge clk);
                if ({halted, axi_arvalid, axi_awvalid, axi_wvalid} !== 4'b1000) begin
                    value_errors++;
                    $display("Fail at %0t: {halted,arvalid,awvalid,wvalid} got %b expected %b",
                             $time, {halted, axi_arvalid, axi_awvalid, axi_wvalid}, 4'b1000);
                    break;
                end
            end
        end
    endtask

    initial begin
        int props_errors;
        reset       = 1'b1;
        axi_arready = 1'b0;
        axi_rdata   = 32'h0;
        axi_rvalid  = 1'b0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        build_table();
        // first pass with a zero-delay slave, second with random delays
        for (int pass = 0; pass < 2; pass++) begin
            for (int n = 0; n < rows.size(); n++) begin
                run_row(n, pass);
            end
        end
        props_errors = rv_core_i.props_i.fail_count;
        $display("error counts: wrong values %0d, timeouts %0d, assertions %0d",
                 value_errors, timeouts, props_errors);
        if (value_errors == 0 && timeouts == 0 && props_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
